/* flist.f */
design/audio_ctrl_pkg.sv
design/host_rx_reader.sv
design/frame_parser.sv
design/session_sequencer.sv
design/output_select.sv
design/audio_ctrl_top.sv
testbench/tb_audio_ctrl.sv

/* Bender.yml */
package:
  name: audio_ctrl

sources:
  - design/audio_ctrl_pkg.sv
  - design/host_rx_reader.sv
  - design/frame_parser.sv
  - design/session_sequencer.sv
  - design/output_select.sv
  - design/audio_ctrl_top.sv
  - target: simulation
    files:
      - testbench/tb_audio_ctrl.sv

/* testbench/tb_audio_ctrl.sv */
// Testbench for the audio command controller
// Models the host input FIFO and both transmitter sinks, then runs setup,
// stream, stop and error sessions and checks them with assertions

`timescale 1ns/100ps

module tb_audio_ctrl;

    localparam int         TIMEOUT_CYCLES = 20000;
    localparam int         STREAM_LEN     = 40;
    // Stopped code 11 with length 1
    localparam logic [7:0] STATUS_HDR     = 8'hC1;

    logic       clk;
    logic       reset_i             = 1'b1;
    logic       rd_in_fifo_en_o;
    logic       rd_in_fifo_empty_i  = 1'b1;
    logic [7:0] rd_in_fifo_data_i   = 8'h00;
    logic       wr_out_fifo_en_o;
    logic [7:0] wr_out_fifo_data_o;
    logic       wr_out_fifo_full_i  = 1'b0;
    logic       wr_out_fifo_afull_i = 1'b0;
    logic       spdif_wr_en_o;
    logic       i2s_wr_en_o;
    logic [7:0] sample_data_o;
    logic       spdif_full_i        = 1'b0;
    logic       i2s_full_i          = 1'b0;
    logic       spdif_streaming_i   = 1'b0;
    logic       i2s_streaming_i     = 1'b0;
    logic       led_ctrl_err_o;
    logic [7:0] led_sr_o;
    logic [3:0] led_depth_o;
    logic       led_streaming_spdif_o;
    logic       led_streaming_i2s_o;

    // Scoreboards and model state
    logic [7:0]  host_q[$];
    logic [7:0]  exp_q[$];
    logic [7:0]  out_q[$];
    logic [31:0] rng          = 32'h7164;
    logic        fifo_read    = 1'b0;
    logic        full_rand_en = 1'b0;
    logic        exp_sink     = 1'b0;
    logic [7:0]  exp_byte;
    int          checks       = 0;
    int          errors       = 0;
    int          cycles       = 0;

    audio_ctrl_top #(
        .SYNC_STAGES (2)
    ) DUT (
        .*
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s: expected %0h, got %0h", $time, name, exp, got);
        end
    endtask

    // Header 00 with length 1, then out_sel, reserved, rate and depth
    task automatic send_setup(input logic [1:0] out_sel, input logic [2:0] rate,
                              input logic [1:0] depth);
        @(negedge clk);
        host_q.push_back(8'h01);
        host_q.push_back({out_sel, 1'b0, rate, depth});
    endtask

    task automatic send_stream(input int n);
        logic [7:0] b;
        @(negedge clk);
        host_q.push_back({2'b01, 6'(n)});
        for (int i = 0; i < n; i++) begin
            rng = next_random(rng);
            b   = rng[7:0];
            host_q.push_back(b);
            exp_q.push_back(b);
        end
    endtask

    task automatic wait_drained();
        while (host_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    // ========================================================================
    // Input FIFO and sink models
    // ========================================================================
    // A read on one edge shows its byte during the next cycle
    always @(negedge clk) begin
        fifo_read = rd_in_fifo_en_o && !rd_in_fifo_empty_i;
    end

    always @(posedge clk) begin
        #1;
        if (fifo_read) begin
            rd_in_fifo_data_i = host_q.pop_front();
        end
        rd_in_fifo_empty_i = (host_q.size() == 0);
    end

    // Random back-pressure from both sinks
    always @(posedge clk) begin
        #1;
        if (full_rand_en) begin
            rng          = next_random(rng);
            spdif_full_i = rng[0];
            i2s_full_i   = rng[8];
        end else begin
            spdif_full_i = 1'b0;
            i2s_full_i   = 1'b0;
        end
    end

    // Sample writes must hit the selected sink in order
    always @(negedge clk) begin
        if (!reset_i && (spdif_wr_en_o || i2s_wr_en_o)) begin
            compare_value("i2s_wr_en_o", i2s_wr_en_o, exp_sink);
            if (exp_q.size() == 0) begin
                errors++;
                $display("%0t: sample write with no byte left to deliver", $time);
            end else begin
                exp_byte = exp_q.pop_front();
                compare_value("sample_data_o", sample_data_o, exp_byte);
            end
        end
    end

    always @(negedge clk) begin
        if (!reset_i && wr_out_fifo_en_o) begin
            out_q.push_back(wr_out_fifo_data_o);
        end
    end

    // Sinks flag full one slot early so a write may only follow a free cycle
    a_spdif_room: assert property (@(posedge clk) disable iff (reset_i)
        spdif_wr_en_o |-> $past(!spdif_full_i))
        else begin
            errors++;
            $display("%0t: S/PDIF write followed a cycle with its full flag set", $time);
        end

    a_i2s_room: assert property (@(posedge clk) disable iff (reset_i)
        i2s_wr_en_o |-> $past(!i2s_full_i))
        else begin
            errors++;
            $display("%0t: I2S write followed a cycle with its full flag set", $time);
        end

    // A full or almost full output FIFO holds off the next status write
    a_out_fifo_room: assert property (@(posedge clk) disable iff (reset_i)
        (wr_out_fifo_full_i || wr_out_fifo_afull_i) |=> !wr_out_fifo_en_o)
        else begin
            errors++;
            $display("%0t: status byte written while the output FIFO had no room", $time);
        end

    a_locked_after_error: assert property (@(posedge clk) disable iff (reset_i)
        led_ctrl_err_o |=> !rd_in_fifo_en_o)
        else begin
            errors++;
            $display("%0t: input FIFO read after the error LED was lit", $time);
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ========================================================================
    // Sessions
    // ========================================================================
    initial begin
        repeat (2) @(posedge clk);
        // Quiet outputs while in reset
        compare_value("rd_in_fifo_en_o", rd_in_fifo_en_o, 0);
        compare_value("wr_out_fifo_en_o", wr_out_fifo_en_o, 0);
        compare_value("spdif_wr_en_o", spdif_wr_en_o, 0);
        compare_value("i2s_wr_en_o", i2s_wr_en_o, 0);
        compare_value("led_ctrl_err_o", led_ctrl_err_o, 0);
        compare_value("led_sr_o", led_sr_o, 0);
        compare_value("led_depth_o", led_depth_o, 0);
        compare_value("led_streaming_spdif_o", led_streaming_spdif_o, 0);
        compare_value("led_streaming_i2s_o", led_streaming_i2s_o, 0);
        #1;
        reset_i = 1'b0;

        // S/PDIF at 176.4 kHz, 16 bit
        exp_sink = 1'b0;
        send_setup(2'b11, 3'b010, 2'b01);
        wait_drained();
        compare_value("led_sr_o", led_sr_o, 8'h04);
        compare_value("led_depth_o", led_depth_o, 4'h2);

        full_rand_en = 1'b1;
        send_stream(STREAM_LEN);
        while (exp_q.size() != 0) @(posedge clk);
        full_rand_en = 1'b0;

        // Stop held off by an active transmitter
        #1;
        spdif_streaming_i = 1'b1;
        repeat (5) @(posedge clk);
        compare_value("led_streaming_spdif_o", led_streaming_spdif_o, 1);
        compare_value("led_streaming_i2s_o", led_streaming_i2s_o, 0);
        @(negedge clk);
        host_q.push_back(8'h80);
        repeat (30) @(posedge clk);
        compare_value("status bytes while streaming", out_q.size(), 0);
        #1;
        wr_out_fifo_afull_i = 1'b1;
        spdif_streaming_i   = 1'b0;
        repeat (10) @(posedge clk);
        compare_value("status bytes while afull", out_q.size(), 0);
        #1;
        wr_out_fifo_afull_i = 1'b0;
        wr_out_fifo_full_i  = 1'b1;
        repeat (10) @(posedge clk);
        compare_value("status bytes while full", out_q.size(), 0);
        #1;
        wr_out_fifo_full_i = 1'b0;
        while (out_q.size() < 2) @(posedge clk);
        compare_value("stop status header", out_q[0], STATUS_HDR);
        compare_value("stop status code", out_q[1], 8'h00);
        out_q.delete();

        // Reading resumes with I2S at 384 kHz and 32 bit
        exp_sink = 1'b1;
        send_setup(2'b01, 3'b111, 2'b11);
        wait_drained();
        compare_value("led_sr_o", led_sr_o, 8'h80);
        compare_value("led_depth_o", led_depth_o, 4'h8);
        full_rand_en = 1'b1;
        send_stream(8);
        while (exp_q.size() != 0) @(posedge clk);
        full_rand_en = 1'b0;

        // Setup with length 2 locks the controller
        @(negedge clk);
        host_q.push_back(8'h02);
        host_q.push_back(8'h00);
        host_q.push_back(8'h00);
        for (int i = 0; i < 4; i++) begin
            host_q.push_back(8'h41);
        end
        while (out_q.size() < 2) @(posedge clk);
        compare_value("error status header", out_q[0], STATUS_HDR);
        compare_value("error status code", out_q[1], 8'h01);
        compare_value("led_ctrl_err_o", led_ctrl_err_o, 1);
        repeat (20) begin
            @(posedge clk);
            compare_value("rd_in_fifo_en_o", rd_in_fifo_en_o, 0);
        end
        compare_value("rd_in_fifo_empty_i", rd_in_fifo_empty_i, 0);
        compare_value("status byte count", out_q.size(), 2);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* design/audio_ctrl_top.sv */
// Top level of the audio command controller
// Connects the FIFO reader, frame parser, session sequencer and output select
// Transmitters and host FIFOs sit outside on the ports

`timescale 1ns/100ps

module audio_ctrl_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic       clk,
    input  logic       reset_i,
    // Host input FIFO
    output logic       rd_in_fifo_en_o,
    input  logic       rd_in_fifo_empty_i,
    input  logic [7:0] rd_in_fifo_data_i,
    // Host output FIFO
    output logic       wr_out_fifo_en_o,
    output logic [7:0] wr_out_fifo_data_o,
    input  logic       wr_out_fifo_full_i,
    input  logic       wr_out_fifo_afull_i,
    // Transmitter sinks
    output logic       spdif_wr_en_o,
    output logic       i2s_wr_en_o,
    output logic [7:0] sample_data_o,
    input  logic       spdif_full_i,
    input  logic       i2s_full_i,
    input  logic       spdif_streaming_i,
    input  logic       i2s_streaming_i,
    // LEDs
    output logic       led_ctrl_err_o,
    output logic [7:0] led_sr_o,
    output logic [3:0] led_depth_o,
    output logic       led_streaming_spdif_o,
    output logic       led_streaming_i2s_o
);

    import audio_ctrl_pkg::*;

    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        rd_allow;
    logic        sink_full;
    logic        streaming;
    audio_cfg_t  cfg;
    sample_wr_t  sample;
    ctrl_event_t evt;

    host_rx_reader u_reader (
        .clk                (clk),
        .reset_i            (reset_i),
        .rd_in_fifo_en_o    (rd_in_fifo_en_o),
        .rd_in_fifo_empty_i (rd_in_fifo_empty_i),
        .rd_in_fifo_data_i  (rd_in_fifo_data_i),
        .rd_allow_i         (rd_allow),
        .sink_full_i        (sink_full),
        .rx_valid_o         (rx_valid),
        .rx_data_o          (rx_data)
    );

    frame_parser u_parser (
        .clk        (clk),
        .reset_i    (reset_i),
        .rx_valid_i (rx_valid),
        .rx_data_i  (rx_data),
        .cfg_o      (cfg),
        .sample_o   (sample),
        .evt_o      (evt)
    );

    session_sequencer u_sequencer (
        .clk                 (clk),
        .reset_i             (reset_i),
        .evt_i               (evt),
        .streaming_i         (streaming),
        .rd_allow_o          (rd_allow),
        .wr_out_fifo_en_o    (wr_out_fifo_en_o),
        .wr_out_fifo_data_o  (wr_out_fifo_data_o),
        .wr_out_fifo_full_i  (wr_out_fifo_full_i),
        .wr_out_fifo_afull_i (wr_out_fifo_afull_i),
        .led_ctrl_err_o      (led_ctrl_err_o)
    );

    output_select #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_output_select (
        .clk                   (clk),
        .reset_i               (reset_i),
        .cfg_i                 (cfg),
        .sample_i              (sample),
        .spdif_full_i          (spdif_full_i),
        .i2s_full_i            (i2s_full_i),
        .spdif_streaming_i     (spdif_streaming_i),
        .i2s_streaming_i       (i2s_streaming_i),
        .spdif_wr_en_o         (spdif_wr_en_o),
        .i2s_wr_en_o           (i2s_wr_en_o),
        .sample_data_o         (sample_data_o),
        .sink_full_o           (sink_full),
        .streaming_o           (streaming),
        .led_sr_o              (led_sr_o),
        .led_depth_o           (led_depth_o),
        .led_streaming_spdif_o (led_streaming_spdif_o),
        .led_streaming_i2s_o   (led_streaming_i2s_o)
    );

endmodule

/* design/output_select.sv */
// Steers sample bytes to the enabled transmitter sink
// Masks the sink full flags, synchronizes the streaming flags and
// drives the rate, depth and streaming LEDs

`timescale 1ns/100ps

module output_select #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  audio_ctrl_pkg::audio_cfg_t cfg_i,
    input  audio_ctrl_pkg::sample_wr_t sample_i,
    input  logic                       spdif_full_i,
    input  logic                       i2s_full_i,
    input  logic                       spdif_streaming_i,
    input  logic                       i2s_streaming_i,
    output logic                       spdif_wr_en_o,
    output logic                       i2s_wr_en_o,
    output logic [7:0]                 sample_data_o,
    output logic                       sink_full_o,
    output logic                       streaming_o,
    output logic [7:0]                 led_sr_o,
    output logic [3:0]                 led_depth_o,
    output logic                       led_streaming_spdif_o,
    output logic                       led_streaming_i2s_o
);

    import audio_ctrl_pkg::*;

    logic [1:0]                  full_vec;
    logic [1:0]                  stream_async;
    logic [SYNC_STAGES-1:0][1:0] sync_q;
    logic [1:0]                  stream_sync;

    // ========================================================================
    // Sample steering
    // ========================================================================
    assign spdif_wr_en_o = sample_i.valid & cfg_i.io_en[IO_TYPE_SPDIF_BIT];
    assign i2s_wr_en_o   = sample_i.valid & cfg_i.io_en[IO_TYPE_I2S_BIT];
    assign sample_data_o = sample_i.data;

    // Writes trail the check by a cycle, so sinks flag full with one slot spare
    assign full_vec[IO_TYPE_SPDIF_BIT] = spdif_full_i;
    assign full_vec[IO_TYPE_I2S_BIT]   = i2s_full_i;
    assign sink_full_o = |(full_vec & cfg_i.io_en);

    // ========================================================================
    // Streaming flag synchronizers
    // ========================================================================
    assign stream_async[IO_TYPE_SPDIF_BIT] = spdif_streaming_i;
    assign stream_async[IO_TYPE_I2S_BIT]   = i2s_streaming_i;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], stream_async};
        end
    end

    assign stream_sync           = sync_q[SYNC_STAGES-1];
    assign streaming_o           = |stream_sync;
    assign led_streaming_spdif_o = stream_sync[IO_TYPE_SPDIF_BIT];
    assign led_streaming_i2s_o   = stream_sync[IO_TYPE_I2S_BIT];

    // Rate and depth LEDs stay dark until an output is set up
    assign led_sr_o    = (|cfg_i.io_en) ? (8'd1 << cfg_i.sample_rate) : 8'd0;
    assign led_depth_o = (|cfg_i.io_en) ? (4'd1 << cfg_i.bit_depth) : 4'd0;

    // Setup decoding must keep io_en one-hot
    property p_single_sink;
        @(posedge clk) disable iff (reset_i)
        !(spdif_wr_en_o && i2s_wr_en_o);
    endproperty
    a_single_sink: assert property (p_single_sink);

endmodule

/* design/session_sequencer.sv */
// Session control for the command path
// Gates input reads, waits for the outputs to stop and writes the
// two byte status message to the host output FIFO

`timescale 1ns/100ps

module session_sequencer (
    input  logic                        clk,
    input  logic                        reset_i,
    input  audio_ctrl_pkg::ctrl_event_t evt_i,
    input  logic                        streaming_i,
    output logic                        rd_allow_o,
    output logic                        wr_out_fifo_en_o,
    output logic [7:0]                  wr_out_fifo_data_o,
    input  logic                        wr_out_fifo_full_i,
    input  logic                        wr_out_fifo_afull_i,
    output logic                        led_ctrl_err_o
);

    import audio_ctrl_pkg::*;

    typedef enum logic [1:0] {
        ST_READ,
        ST_WAIT_STOP,
        ST_STATUS,
        ST_IDLE
    } state_e;

    state_e     state_q;
    logic       code_sel_q;
    logic [7:0] code_q;

    assign rd_allow_o = (state_q == ST_READ);

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q          <= ST_READ;
            code_sel_q       <= 1'b0;
            wr_out_fifo_en_o <= 1'b0;
            led_ctrl_err_o   <= 1'b0;
        end else begin
            wr_out_fifo_en_o <= 1'b0;
            case (state_q)
                ST_READ: begin
                    code_sel_q <= 1'b0;
                    if (evt_i.error) begin
                        // Error LED also locks the sequencer after the status
                        led_ctrl_err_o <= 1'b1;
                        state_q        <= ST_STATUS;
                    end else if (evt_i.stop_req) begin
                        state_q <= ST_WAIT_STOP;
                    end
                end
                ST_WAIT_STOP: begin
                    if (!streaming_i) begin
                        state_q <= ST_STATUS;
                    end
                end
                ST_STATUS: begin
                    // Header first, then the code byte
                    if (!wr_out_fifo_full_i && !wr_out_fifo_afull_i) begin
                        wr_out_fifo_en_o <= 1'b1;
                        code_sel_q       <= 1'b1;
                        if (code_sel_q) begin
                            state_q <= led_ctrl_err_o ? ST_IDLE : ST_READ;
                        end
                    end
                end
                // Left only through reset
                ST_IDLE: begin
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Status code and output byte
    always_ff @(posedge clk) begin
        if (state_q == ST_READ && evt_i.error) begin
            code_q <= evt_i.error_code;
        end else if (state_q == ST_WAIT_STOP) begin
            code_q <= ERROR_NONE;
        end
        if (state_q == ST_STATUS) begin
            wr_out_fifo_data_o <= code_sel_q ? code_q : {CMD_FPGA_STOPPED, STATUS_LEN};
        end
    end

    // A full output FIFO blocks the write on the next edge
    property p_no_write_when_full;
        @(posedge clk) disable iff (reset_i)
        wr_out_fifo_full_i |=> !wr_out_fifo_en_o;
    endproperty
    a_no_write_when_full: assert property (p_no_write_when_full);

endmodule

/* design/frame_parser.sv */
// Frames host bytes into command headers and payloads
// Holds the audio configuration, issues sample writes and reports
// stop requests and length errors to the sequencer

`timescale 1ns/100ps

module frame_parser (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     rx_valid_i,
    input  audio_ctrl_pkg::ctrl_byte_u  rx_data_i,
    output audio_ctrl_pkg::audio_cfg_t  cfg_o,
    output audio_ctrl_pkg::sample_wr_t  sample_o,
    output audio_ctrl_pkg::ctrl_event_t evt_o
);

    import audio_ctrl_pkg::*;

    logic        in_payload_q;
    logic [1:0]  cmd_q;
    logic [5:0]  left_q;
    audio_cfg_t  cfg_q;
    sample_wr_t  sample_q;
    ctrl_event_t evt_q;

    assign cfg_o    = cfg_q;
    assign sample_o = sample_q;
    assign evt_o    = evt_q;

    // ========================================================================
    // Header and payload framing
    // ========================================================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            in_payload_q   <= 1'b0;
            cmd_q          <= CMD_HOST_SETUP_OUTPUT;
            left_q         <= '0;
            cfg_q          <= '0;
            sample_q       <= '0;
            evt_q          <= '0;
        end else begin
            // Pulses
            sample_q.valid <= 1'b0;
            evt_q.stop_req <= 1'b0;
            evt_q.error    <= 1'b0;

            if (rx_valid_i && !in_payload_q) begin
                cmd_q        <= rx_data_i.hdr.cmd;
                left_q       <= rx_data_i.hdr.len;
                in_payload_q <= (rx_data_i.hdr.len != 6'd0);
                case (rx_data_i.hdr.cmd)
                    CMD_HOST_SETUP_OUTPUT: begin
                        if (rx_data_i.hdr.len != 6'd1) begin
                            evt_q.error      <= 1'b1;
                            evt_q.error_code <= ERROR_INVALID_SETUP_PAYLOAD;
                            // Bad setup payload gets skipped, never applied
                            cmd_q <= CMD_FPGA_STOPPED;
                        end
                    end
                    CMD_HOST_STOP: begin
                        if (rx_data_i.hdr.len != 6'd0) begin
                            evt_q.error      <= 1'b1;
                            evt_q.error_code <= ERROR_INVALID_STOP_PAYLOAD;
                        end else begin
                            evt_q.stop_req   <= 1'b1;
                            evt_q.error_code <= ERROR_NONE;
                        end
                    end
                    default: begin
                    end
                endcase
            end else if (rx_valid_i) begin
                left_q <= left_q - 6'd1;
                if (left_q == 6'd1) begin
                    in_payload_q <= 1'b0;
                end
                // Sample payload
                sample_q.data <= rx_data_i;
                case (cmd_q)
                    CMD_HOST_SETUP_OUTPUT: begin
                        // Either output maps onto one of the two sinks
                        cfg_q.io_en <= rx_data_i.setup.out_sel[1] ?
                                       2'(1 << IO_TYPE_SPDIF_BIT) :
                                       2'(1 << IO_TYPE_I2S_BIT);
                        cfg_q.sample_rate <= rx_data_i.setup.rate;
                        cfg_q.bit_depth   <= rx_data_i.setup.depth;
                    end
                    CMD_HOST_STREAM_OUTPUT: begin
                        sample_q.valid <= 1'b1;
                    end
                    // Stop and status codes carry nothing useful here
                    default: begin
                    end
                endcase
            end
        end
    end

    // A header raises either a stop or an error, never both
    property p_evt_exclusive;
        @(posedge clk) disable iff (reset_i)
        !(evt_q.stop_req && evt_q.error);
    endproperty
    a_evt_exclusive: assert property (p_evt_exclusive);

endmodule

/* design/host_rx_reader.sv */
// Reads host bytes from the input FIFO and hands them to the frame parser
// One byte is held back when the enabled sink pushes back

`timescale 1ns/100ps

module host_rx_reader (
    input  logic       clk,
    input  logic       reset_i,
    output logic       rd_in_fifo_en_o,
    input  logic       rd_in_fifo_empty_i,
    input  logic [7:0] rd_in_fifo_data_i,
    input  logic       rd_allow_i,
    input  logic       sink_full_i,
    output logic       rx_valid_o,
    output logic [7:0] rx_data_o
);

    logic       rd_pend_q;
    logic       saved_q;
    logic [7:0] hold_q;
    logic       rd_now;
    logic       saved_d;
    logic       en_d;

    // A read lands on this edge
    assign rd_now = rd_in_fifo_en_o & ~rd_in_fifo_empty_i;

    // Deliver FIFO data or the held byte once the sink has room
    assign rx_valid_o = (rd_pend_q | saved_q) & ~sink_full_i;
    assign rx_data_o  = saved_q ? hold_q : rd_in_fifo_data_i;

    // Keep or take the byte while the sink is full
    assign saved_d = (saved_q | rd_pend_q) & sink_full_i;

    // Enable skips the data cycle so only one byte is ever in flight
    assign en_d = rd_allow_i & ~sink_full_i & ~saved_d & ~rd_now;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            rd_in_fifo_en_o <= 1'b0;
            rd_pend_q       <= 1'b0;
            saved_q         <= 1'b0;
        end else begin
            rd_in_fifo_en_o <= en_d;
            rd_pend_q       <= rd_now;
            saved_q         <= saved_d;
        end
    end

    // Holding register
    always_ff @(posedge clk) begin
        if (rd_pend_q && sink_full_i) begin
            hold_q <= rd_in_fifo_data_i;
        end
    end

    // No new read may start while a byte waits for the sink
    property p_no_read_while_saved;
        @(posedge clk) disable iff (reset_i)
        saved_q |-> !rd_in_fifo_en_o;
    endproperty
    a_no_read_while_saved: assert property (p_no_read_while_saved);

endmodule

/* design/audio_ctrl_pkg.sv */
// Shared definitions for the audio playback command controller
// Command and error codes, rate and depth encodings and the bus structs
// Modules import this package inside their bodies

package audio_ctrl_pkg;

    // ========================================================================
    // Command codes carried in the top two bits of a header byte
    // ========================================================================
    localparam logic [1:0] CMD_HOST_SETUP_OUTPUT  = 2'b00;
    localparam logic [1:0] CMD_HOST_STREAM_OUTPUT = 2'b01;
    localparam logic [1:0] CMD_HOST_STOP          = 2'b10;
    // Only sent back to the host
    localparam logic [1:0] CMD_FPGA_STOPPED       = 2'b11;

    // Length field of the status message header
    localparam logic [5:0] STATUS_LEN = 6'd1;

    // Error codes reported in the second status byte
    localparam logic [7:0] ERROR_NONE                  = 8'd0;
    localparam logic [7:0] ERROR_INVALID_SETUP_PAYLOAD = 8'd1;
    localparam logic [7:0] ERROR_INVALID_STOP_PAYLOAD  = 8'd2;

    // Sample rates where bit 2 selects the 48 kHz family
    localparam logic [2:0] RATE_44K1  = 3'b000;
    localparam logic [2:0] RATE_88K2  = 3'b001;
    localparam logic [2:0] RATE_176K4 = 3'b010;
    localparam logic [2:0] RATE_352K8 = 3'b011;
    localparam logic [2:0] RATE_48K   = 3'b100;
    localparam logic [2:0] RATE_96K   = 3'b101;
    localparam logic [2:0] RATE_192K  = 3'b110;
    localparam logic [2:0] RATE_384K  = 3'b111;

    // Bit depths
    localparam logic [1:0] DEPTH_DOP = 2'b00;
    localparam logic [1:0] DEPTH_16  = 2'b01;
    localparam logic [1:0] DEPTH_24  = 2'b10;
    localparam logic [1:0] DEPTH_32  = 2'b11;

    // Positions inside io_en
    localparam int IO_TYPE_SPDIF_BIT = 0;
    localparam int IO_TYPE_I2S_BIT   = 1;

    // ========================================================================
    // Incoming byte, read as a header or as a setup payload
    // ========================================================================
    typedef struct packed {
        logic [1:0] cmd;
        logic [5:0] len;
    } hdr_t;

    // out_sel 0x picks I2S, 1x picks S/PDIF
    typedef struct packed {
        logic [1:0] out_sel;
        logic       rsvd;
        logic [2:0] rate;
        logic [1:0] depth;
    } setup_t;

    typedef union packed {
        hdr_t   hdr;
        setup_t setup;
    } ctrl_byte_u;

    // Active audio configuration
    typedef struct packed {
        logic [1:0] io_en;
        logic [2:0] sample_rate;
        logic [1:0] bit_depth;
    } audio_cfg_t;

    // One sample byte toward the sinks
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } sample_wr_t;

    // Single cycle events from the parser
    typedef struct packed {
        logic       stop_req;
        logic       error;
        logic [7:0] error_code;
    } ctrl_event_t;

endpackage
